//--- verilog/dfe_reconfig_pkg.sv
// fixed 4 channels, 4 taps each packed two per 16-bit word; no logical channel map, no streaming
package dfe_reconfig_pkg;

   localparam int num_channels = 4;             // physical channels only

   typedef logic [$clog2(num_channels)-1:0] chan_t;  // physical channel number
   typedef logic [2:0]  tap_sel_t;              // 0..3 taps, 4 = calibration
   typedef logic [7:0]  tap_t;                  // tap value or cal code
   typedef logic [15:0] data16_t;               // basic-block data word
   typedef logic [3:0]  hw_off_t;               // word offset inside one channel
   typedef logic [$bits(chan_t)+$bits(hw_off_t)-1:0] base_addr_t;  // {chan, offset}
   typedef logic [2:0]  host_addr_t;            // host register select

   // host register map
   localparam host_addr_t reg_chan   = 3'd0;
   localparam host_addr_t reg_offset = 3'd1;
   localparam host_addr_t reg_data   = 3'd2;
   localparam host_addr_t reg_ctrl   = 3'd3;

   localparam tap_sel_t cal_select = 3'd4;      // above this is illegal

   // basic-block layout
   localparam hw_off_t tap_word_base = 4'd2;    // taps 0/1 at 2, taps 2/3 at 3
   localparam hw_off_t cal_reg_off   = 4'd8;    // offset-cancel code register

   // calibration sweep
   localparam tap_t cal_code_max  = 8'd63;      // last code tried
   localparam int   settle_cycles = 8;          // comparator settle after each write

   // reg_ctrl bit positions
   localparam int ctrl_write_bit = 0;
   localparam int ctrl_read_bit  = 1;
   localparam int busy_bit       = 8;
   localparam int error_bit      = 9;           // sticky, write 1 to clear

   // offset-cancellation sweep states
   typedef enum logic [2:0] {
      cal_idle,
      cal_write_code,
      cal_settle,
      cal_sample,
      cal_finish
   } cal_state_t;

endpackage

//--- verilog/dfe_user_if.sv
// one command at a time; reg_ctrl writes stall while busy, error is sticky until written with 1
module dfe_user_if import dfe_reconfig_pkg::*; (
   input  logic        reconfig_clk,
   input  logic        rst_n,
   input  host_addr_t  host_addr,
   input  logic [31:0] host_wdata,
   input  logic        host_write,
   input  logic        host_read,
   input  logic        tap_done,
   input  tap_t        tap_rdata,
   input  logic        cal_done,
   input  tap_t        cal_result,
   output logic [31:0] host_rdata,
   output logic        host_waitrequest,
   output logic        host_done,
   output chan_t       chan,
   output tap_sel_t    tap_sel,
   output tap_t        wdata,
   output logic        tap_go,
   output logic        tap_write,
   output logic        cal_go
);

   logic busy, error;
   tap_t result;                               // last tap read or cal code
   logic ctrl_wr, cmd_wr, cmd_rd, cmd_start, cmd_bad;

   // reg_ctrl write accepted only when idle
   assign ctrl_wr   = host_write && (host_addr == reg_ctrl) && !busy;
   assign cmd_wr    = ctrl_wr && host_wdata[ctrl_write_bit];
   assign cmd_rd    = ctrl_wr && host_wdata[ctrl_read_bit] && !cmd_wr;  // write wins
   assign cmd_start = cmd_wr || cmd_rd;
   // out of range, or a read of the cal select
   assign cmd_bad   = (tap_sel > cal_select) || ((tap_sel == cal_select) && cmd_rd);

   assign host_waitrequest = host_write && (host_addr == reg_ctrl) && busy;  // hold until idle

   always_comb begin
      host_rdata = '0;
      if (host_read) begin
         case (host_addr)
            reg_chan:   host_rdata = 32'(chan);
            reg_offset: host_rdata = 32'(tap_sel);
            reg_data:   host_rdata = 32'(result);
            reg_ctrl: begin
               host_rdata[busy_bit]  = busy;
               host_rdata[error_bit] = error;
            end
            default:    host_rdata = '0;
         endcase
      end
   end

   always_ff @(posedge reconfig_clk) begin
      if (!rst_n) begin
         chan <= '0;
         tap_sel <= '0;
         wdata <= '0;
         result <= '0;
         busy <= 1'b0;
         error <= 1'b0;
         host_done <= 1'b0;
         tap_go <= 1'b0;
         tap_write <= 1'b0;
         cal_go <= 1'b0;
      end else begin
         tap_go <= 1'b0;                        // go lines are single pulses
         cal_go <= 1'b0;
         host_done <= tap_done || cal_done;     // end of a started command
         if (tap_done) result <= tap_rdata;
         if (cal_done) result <= cal_result;
         if (tap_done || cal_done) busy <= 1'b0;   // falls with host_done
         if (host_write && host_addr == reg_chan)   chan    <= host_wdata[$bits(chan_t)-1:0];
         if (host_write && host_addr == reg_offset) tap_sel <= host_wdata[2:0];
         if (host_write && host_addr == reg_data)   wdata   <= host_wdata[7:0];
         if (ctrl_wr && host_wdata[error_bit]) error <= 1'b0;  // w1c
         if (cmd_start) begin
            if (cmd_bad) begin
               error <= 1'b1;
               host_done <= 1'b1;               // rejected but still acknowledged
            end else if (tap_sel == cal_select) begin
               cal_go <= 1'b1;
               busy <= 1'b1;
            end else begin
               tap_go <= 1'b1;
               tap_write <= cmd_wr;
               busy <= 1'b1;
            end
         end
      end
   end

   // completions only for a command we launched
   a_done_when_busy: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
      (tap_done || cal_done) |-> busy);

endmodule

//--- verilog/dfe_tap_map.sv
// tap_sel assumed 0..3, checked upstream; a write is a locked read-modify-write of one word
module dfe_tap_map import dfe_reconfig_pkg::*; (
   input  logic       reconfig_clk,
   input  logic       rst_n,
   input  logic       tap_go,
   input  logic       tap_write,
   input  chan_t      chan,
   input  tap_sel_t   tap_sel,
   input  tap_t       wdata,
   input  logic       bus_done,
   input  data16_t    bus_rdata,
   output logic       tap_done,
   output tap_t       tap_rdata,
   output logic       bus_go,
   output logic       bus_write,
   output logic       bus_lock,
   output base_addr_t bus_addr,
   output data16_t    bus_wdata
);

   typedef enum logic [1:0] {map_idle, map_read, map_write} map_state_t;

   map_state_t state;
   chan_t      chan_q;                          // captured at go
   tap_sel_t   sel_q;
   tap_t       wdata_q;
   logic       write_q;
   data16_t    word_q;                          // merged word for write-back
   hw_off_t    word_off;
   tap_t       rd_byte;

   assign word_off = tap_word_base + hw_off_t'(sel_q[1]);        // two taps per word
   assign rd_byte  = sel_q[0] ? bus_rdata[15:8] : bus_rdata[7:0];  // odd tap in high byte

   assign bus_addr  = {chan_q, word_off};
   assign bus_wdata = word_q;
   assign bus_write = (state == map_write);
   assign bus_lock  = (state == map_read) && write_q;  // keep bus across rmw

   always_ff @(posedge reconfig_clk) begin
      if (tap_go) begin
         chan_q  <= chan;
         sel_q   <= tap_sel;
         wdata_q <= wdata;
         write_q <= tap_write;
      end
      if (state == map_read && bus_done)        // splice new byte into old word
         word_q <= sel_q[0] ? {wdata_q, bus_rdata[7:0]} : {bus_rdata[15:8], wdata_q};
   end

   always_ff @(posedge reconfig_clk) begin
      if (!rst_n) begin
         state <= map_idle;
         bus_go <= 1'b0;
         tap_done <= 1'b0;
         tap_rdata <= '0;
      end else begin
         bus_go <= 1'b0;
         tap_done <= 1'b0;
         case (state)
            map_idle: if (tap_go) begin
               bus_go <= 1'b1;                  // read first in both cases
               state <= map_read;
            end
            map_read: if (bus_done) begin
               if (write_q) begin
                  bus_go <= 1'b1;
                  state <= map_write;
               end else begin
                  tap_rdata <= rd_byte;
                  tap_done <= 1'b1;
                  state <= map_idle;
               end
            end
            map_write: if (bus_done) begin
               tap_rdata <= wdata_q;            // echo written value
               tap_done <= 1'b1;
               state <= map_idle;
            end
            default: state <= map_idle;
         endcase
      end
   end

endmodule

//--- verilog/dfe_cal_fsm.sv
// linear sweep from code 0, stops on comparator trip or at cal_code_max; bus never locked
module dfe_cal_fsm import dfe_reconfig_pkg::*; (
   input  logic       reconfig_clk,
   input  logic       rst_n,
   input  logic       cal_go,
   input  chan_t      chan,
   input  logic       bus_done,
   input  logic       expire,
   input  logic [7:0] dfe_testbus,
   output logic       cal_done,
   output tap_t       cal_result,
   output logic       bus_go,
   output base_addr_t bus_addr,
   output data16_t    bus_wdata,
   output logic       timer_load
);

   cal_state_t state;
   chan_t      chan_q;                          // channel under calibration
   tap_t       code;                            // current offset code
   logic       trip;

   assign trip = dfe_testbus[0];                // comparator output

   assign bus_addr   = {chan_q, cal_reg_off};
   assign bus_wdata  = {8'h00, code};
   assign timer_load = (state == cal_write_code) && bus_done;  // start settle on write end
   assign cal_done   = (state == cal_finish);

   always_ff @(posedge reconfig_clk) begin
      if (state == cal_idle && cal_go)
         chan_q <= chan;
   end

   always_ff @(posedge reconfig_clk) begin
      if (!rst_n) begin
         state <= cal_idle;
         code <= '0;
         cal_result <= '0;
         bus_go <= 1'b0;
      end else begin
         bus_go <= 1'b0;
         case (state)
            cal_idle: begin
               if (cal_go) begin
                  code <= '0;                   // always sweep from the bottom
                  bus_go <= 1'b1;
                  state <= cal_write_code;
               end
            end
            cal_write_code: begin
               if (bus_done)
                  state <= cal_settle;
            end
            cal_settle: begin
               if (expire)
                  state <= cal_sample;          // comparator now valid
            end
            cal_sample: begin
               if (trip || code == cal_code_max) begin
                  cal_result <= code;
                  state <= cal_finish;
               end else begin
                  code <= code + 8'd1;          // next code
                  bus_go <= 1'b1;
                  state <= cal_write_code;
               end
            end
            cal_finish: begin
               state <= cal_idle;               // one-cycle done
            end
            default: begin
               state <= cal_idle;
            end
         endcase
      end
   end

   // settle timer ends a full settle_cycles after the code write, and only while we wait
   a_expire_after_settle: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
      expire |-> ($past(timer_load, settle_cycles) && (state == cal_settle)));

endmodule

//--- verilog/dfe_settle_timer.sv
// expire fires settle_cycles cycles after load; a new load while running is not allowed
module dfe_settle_timer import dfe_reconfig_pkg::*; (
   input  logic reconfig_clk,
   input  logic rst_n,
   input  logic load,
   output logic expire
);

   logic [$clog2(settle_cycles)-1:0] cnt;
   logic run;

   assign expire = run && (cnt == '0);          // single pulse at zero

   always_ff @(posedge reconfig_clk) begin
      if (!rst_n) begin
         cnt <= '0;
         run <= 1'b0;
      end else if (load) begin
         cnt <= ($bits(cnt))'(settle_cycles - 1);  // zero reached on cycle settle_cycles
         run <= 1'b1;
      end else if (run) begin
         if (cnt == '0)
            run <= 1'b0;
         else
            cnt <= cnt - 1'b1;
      end
   end

   // cal fsm waits for expire before reloading
   a_no_reload: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
      load |-> !run);

endmodule

//--- verilog/dfe_basic_master.sv
// one transfer per go; arb_req held across locked transfers, bus outputs held during waitrequest
module dfe_basic_master import dfe_reconfig_pkg::*; (
   input  logic       reconfig_clk,
   input  logic       rst_n,
   input  logic       tap_bus_go,
   input  logic       tap_bus_write,
   input  logic       tap_bus_lock,
   input  base_addr_t tap_bus_addr,
   input  data16_t    tap_bus_wdata,
   input  logic       cal_bus_go,
   input  base_addr_t cal_bus_addr,
   input  data16_t    cal_bus_wdata,
   input  data16_t    base_rdata,
   input  logic       base_waitrequest,
   input  logic       arb_grant,
   output logic       bus_done,
   output data16_t    bus_rdata,
   output base_addr_t base_addr,
   output data16_t    base_wdata,
   output logic       base_write,
   output logic       base_read,
   output logic       arb_req
);

   typedef enum logic [1:0] {mst_idle, mst_grant, mst_xfer} mst_state_t;

   mst_state_t state;
   logic       write_q, lock_q;

   // address and data latched from whichever requester fired
   always_ff @(posedge reconfig_clk) begin
      if (state == mst_idle && tap_bus_go) begin
         base_addr  <= tap_bus_addr;
         base_wdata <= tap_bus_wdata;
      end else if (state == mst_idle && cal_bus_go) begin
         base_addr  <= cal_bus_addr;
         base_wdata <= cal_bus_wdata;
      end
      if (state == mst_xfer && !base_waitrequest)
         bus_rdata <= base_rdata;               // valid only on a read
   end

   always_ff @(posedge reconfig_clk) begin
      if (!rst_n) begin
         state <= mst_idle;
         write_q <= 1'b0;
         lock_q <= 1'b0;
         arb_req <= 1'b0;
         base_write <= 1'b0;
         base_read <= 1'b0;
         bus_done <= 1'b0;
      end else begin
         bus_done <= 1'b0;
         case (state)
            mst_idle: if (tap_bus_go || cal_bus_go) begin
               write_q <= tap_bus_go ? tap_bus_write : 1'b1;  // cal only writes
               lock_q <= tap_bus_go && tap_bus_lock;
               arb_req <= 1'b1;                 // may already be high under lock
               state <= mst_grant;
            end
            mst_grant: if (arb_grant) begin
               base_write <= write_q;
               base_read <= !write_q;
               state <= mst_xfer;
            end
            mst_xfer: if (!base_waitrequest) begin
               base_write <= 1'b0;
               base_read <= 1'b0;
               bus_done <= 1'b1;
               if (!lock_q) arb_req <= 1'b0;    // release after last of sequence
               state <= mst_idle;
            end
            default: state <= mst_idle;
         endcase
      end
   end

   // tap map and cal fsm never share the bus at once
   a_one_requester: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
      !(tap_bus_go && cal_bus_go));

   // requesters wait for done before the next go
   a_go_when_idle: assert property (@(posedge reconfig_clk) disable iff (!rst_n)
      (tap_bus_go || cal_bus_go) |-> (state == mst_idle));

endmodule

//--- verilog/dfe_reconfig_top.sv
// 4 fixed physical channels, single arbiter req/grant pair, basic-block irq not used
module dfe_reconfig_top import dfe_reconfig_pkg::*; (
   input  logic        reconfig_clk,
   input  logic        rst_n,
   // host register port
   input  host_addr_t  host_addr,
   input  logic [31:0] host_wdata,
   input  logic        host_write,
   input  logic        host_read,
   output logic [31:0] host_rdata,
   output logic        host_waitrequest,
   output logic        host_done,
   // basic block
   output base_addr_t  base_addr,
   output data16_t     base_wdata,
   output logic        base_write,
   output logic        base_read,
   input  data16_t     base_rdata,
   input  logic        base_waitrequest,
   output logic        arb_req,
   input  logic        arb_grant,
   input  logic [7:0]  dfe_testbus
);

   chan_t      chan;
   tap_sel_t   tap_sel;
   tap_t       wdata, tap_rdata, cal_result;
   logic       tap_go, tap_write, tap_done, cal_go, cal_done;
   logic       bus_done, timer_load, expire;
   data16_t    bus_rdata, tap_bus_wdata, cal_bus_wdata;
   logic       tap_bus_go, tap_bus_write, tap_bus_lock, cal_bus_go;
   base_addr_t tap_bus_addr, cal_bus_addr;

   dfe_user_if inst_user_if (
      .reconfig_clk, .rst_n, .host_addr, .host_wdata, .host_write, .host_read,
      .tap_done, .tap_rdata, .cal_done, .cal_result,
      .host_rdata, .host_waitrequest, .host_done,
      .chan, .tap_sel, .wdata, .tap_go, .tap_write, .cal_go
   );

   dfe_tap_map inst_tap_map (
      .reconfig_clk, .rst_n, .tap_go, .tap_write, .chan, .tap_sel, .wdata,
      .bus_done, .bus_rdata, .tap_done, .tap_rdata,
      .bus_go (tap_bus_go), .bus_write (tap_bus_write), .bus_lock (tap_bus_lock),
      .bus_addr (tap_bus_addr), .bus_wdata (tap_bus_wdata)
   );

   dfe_cal_fsm inst_cal_fsm (
      .reconfig_clk, .rst_n, .cal_go, .chan, .bus_done, .expire, .dfe_testbus,
      .cal_done, .cal_result, .bus_go (cal_bus_go), .bus_addr (cal_bus_addr),
      .bus_wdata (cal_bus_wdata), .timer_load
   );

   dfe_settle_timer inst_settle_timer (
      .reconfig_clk, .rst_n, .load (timer_load), .expire
   );

   dfe_basic_master inst_basic_master (
      .reconfig_clk, .rst_n, .tap_bus_go, .tap_bus_write, .tap_bus_lock, .tap_bus_addr,
      .tap_bus_wdata, .cal_bus_go, .cal_bus_addr, .cal_bus_wdata,
      .base_rdata, .base_waitrequest, .arb_grant, .bus_done, .bus_rdata,
      .base_addr, .base_wdata, .base_write, .base_read, .arb_req
   );

endmodule

//--- tb/dfe_base_model.sv
// behavioral basic block; 64 words filled from the address, comparator per channel, no irq
module dfe_base_model import dfe_reconfig_pkg::*; (
   input  logic       reconfig_clk,
   input  logic       rst_n,
   input  base_addr_t base_addr,
   input  data16_t    base_wdata,
   input  logic       base_write,
   input  logic       base_read,
   output data16_t    base_rdata,
   output logic       base_waitrequest,
   input  logic       arb_req,
   output logic       arb_grant,
   output logic [7:0] dfe_testbus,
   input  logic       thr_set,                  // threshold load from the testbench
   input  chan_t      thr_chan,
   input  tap_t       thr_value
);
   timeunit 1ns;
   timeprecision 100ps;

   data16_t     mem [64];
   tap_t        thresh [num_channels];          // comparator trip point per channel
   integer      seed = 32'h20ff901e;
   logic [31:0] rnd;
   logic [1:0]  gnt_wait, xfer_wait;            // remaining grant / waitrequest cycles
   chan_t       ch;
   tap_t        cal_code;

   initial begin
      for (logic [6:0] a = 7'd0; a < 7'd64; a++)
         mem[a[5:0]] = {2'b10, a[5:0], 2'b01, a[5:0]};  // high 0x80+addr, low 0x40+addr
   end

   assign ch               = base_addr[5:4];
   assign cal_code         = mem[{ch, cal_reg_off}][7:0];   // code last written by the sweep
   assign dfe_testbus      = {7'd0, cal_code >= thresh[ch]};
   assign base_rdata       = base_read ? mem[base_addr] : 16'h0000;  // data only on a read
   assign base_waitrequest = (base_read || base_write) && (xfer_wait != 2'd0);

   always @(posedge reconfig_clk) begin
      rnd = $random(seed);
      if (!rst_n) begin
         arb_grant <= 1'b0;
         gnt_wait  <= 2'd0;
         xfer_wait <= 2'd0;
         thresh    <= '{default: 8'hff};        // never trips, sweep runs to the end
      end else begin
         if (thr_set) thresh[thr_chan] <= thr_value;
         if (!arb_req) begin
            arb_grant <= 1'b0;
            gnt_wait  <= rnd[1:0];              // delay for the next request
         end else if (!arb_grant) begin
            if (gnt_wait == 2'd0) arb_grant <= 1'b1;
            else gnt_wait <= gnt_wait - 2'd1;
         end
         if (!(base_read || base_write)) xfer_wait <= rnd[3:2];
         else if (xfer_wait != 2'd0) xfer_wait <= xfer_wait - 2'd1;
         if (base_write && !base_waitrequest) mem[base_addr] <= base_wdata;
      end
   end

endmodule

//--- tb/dfe_reconfig_tb.sv
// reads tb/dfe_testdata.txt relative to the project root; stops at the first mismatch
module dfe_reconfig_tb import dfe_reconfig_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   logic        reconfig_clk, rst_n;
   host_addr_t  host_addr;
   logic [31:0] host_wdata, host_rdata;
   logic        host_write, host_read, host_waitrequest, host_done;
   base_addr_t  base_addr;
   data16_t     base_wdata, base_rdata;
   logic        base_write, base_read, base_waitrequest, arb_req, arb_grant;
   logic [7:0]  dfe_testbus;
   logic        thr_set;
   chan_t       thr_chan;
   tap_t        thr_value;

   logic [31:0] rec_op[$], rec_chan[$], rec_off[$], rec_data[$], rec_exp[$];
   int          n_rec = 0;
   logic        loaded = 1'b0;                  // file read, watchdog may start
   int          done_count = 0;                 // host_done pulses seen

   dfe_reconfig_top i_dut (
      .reconfig_clk, .rst_n, .host_addr, .host_wdata, .host_write, .host_read,
      .host_rdata, .host_waitrequest, .host_done, .base_addr, .base_wdata,
      .base_write, .base_read, .base_rdata, .base_waitrequest, .arb_req, .arb_grant,
      .dfe_testbus
   );

   dfe_base_model i_base_model (
      .reconfig_clk, .rst_n, .base_addr, .base_wdata, .base_write, .base_read,
      .base_rdata, .base_waitrequest, .arb_req, .arb_grant, .dfe_testbus,
      .thr_set, .thr_chan, .thr_value
   );

   initial begin
      reconfig_clk = 1'b0;
      forever #5 reconfig_clk = ~reconfig_clk;
   end

   always @(negedge reconfig_clk)
      if (host_done) done_count++;             // host_done is a flop, stable here

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         $display("Something failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // called on a falling edge, returns on a falling edge
   task automatic write_reg(input host_addr_t addr, input logic [31:0] data, output int stalls);
      stalls = 0;
      host_addr  = addr;
      host_wdata = data;
      host_write = 1'b1;
      #1;
      while (host_waitrequest) begin           // held while a command runs
         stalls++;
         @(negedge reconfig_clk);
         #1;
      end
      @(negedge reconfig_clk);
      host_write = 1'b0;
   endtask

   task automatic read_reg(input host_addr_t addr, output logic [31:0] data);
      host_addr = addr;
      host_read = 1'b1;
      #1 data = host_rdata;                     // combinational, same cycle
      @(negedge reconfig_clk);
      host_read = 1'b0;
   endtask

   task automatic wait_done();
      while (!host_done) @(negedge reconfig_clk);  // watchdog bounds this
   endtask

   task automatic load_regs(input logic [31:0] ch, input logic [31:0] off,
                            input logic [31:0] dat);
      int stalls;
      write_reg(reg_chan, ch, stalls);
      write_reg(reg_offset, off, stalls);
      write_reg(reg_data, dat, stalls);
   endtask

   task automatic run_command(input logic [31:0] ch, input logic [31:0] off,
                              input logic [31:0] dat, input logic [31:0] ctrl);
      int stalls;
      load_regs(ch, off, dat);
      write_reg(reg_ctrl, ctrl, stalls);
      wait_done();
   endtask

   task automatic set_threshold(input logic [31:0] ch, input logic [31:0] value);
      thr_chan  = chan_t'(ch);
      thr_value = tap_t'(value);
      thr_set   = 1'b1;
      @(negedge reconfig_clk);
      thr_set   = 1'b0;
   endtask

   initial begin
      int          fd, stalls, done_start;
      string       line;
      logic [31:0] op, ch, off, dat, ex, rd;
      host_addr  = '0;
      host_wdata = '0;
      host_write = 1'b0;
      host_read  = 1'b0;
      thr_set    = 1'b0;
      thr_chan   = '0;
      thr_value  = '0;
      rst_n      = 1'b0;
      fd = $fopen("tb/dfe_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open tb/dfe_testdata.txt for reading");
         $display("Something failed");
         $fatal(1, "no test data");
      end else begin
         while ($fgets(line, fd) > 0) begin
            if ($sscanf(line, "%h %h %h %h %h", op, ch, off, dat, ex) == 5) begin
               rec_op.push_back(op);            // comment lines do not scan
               rec_chan.push_back(ch);
               rec_off.push_back(off);
               rec_data.push_back(dat);
               rec_exp.push_back(ex);
            end
         end
         $fclose(fd);
      end
      n_rec  = rec_op.size();
      loaded = 1'b1;

      repeat (3) @(negedge reconfig_clk);
      rst_n = 1'b1;
      host_addr  = reg_ctrl;                    // idle reg_ctrl write, no command bits
      host_wdata = '0;
      host_write = 1'b1;
      #1;
      check("host_waitrequest", 32'(host_waitrequest), 32'd0);
      check("host_done", 32'(host_done), 32'd0);
      check("arb_req", 32'(arb_req), 32'd0);
      check("base_write", 32'(base_write), 32'd0);
      check("base_read", 32'(base_read), 32'd0);
      @(negedge reconfig_clk);
      host_write = 1'b0;
      read_reg(reg_ctrl, rd);
      check("reg_ctrl", rd, 32'd0);

      foreach (rec_op[i]) begin
         case (rec_op[i])
            32'd0, 32'd1, 32'd2: begin         // tap write, tap read, calibration
               run_command(rec_chan[i], rec_off[i], rec_data[i],
                           (rec_op[i] == 32'd1) ? 32'd2 : 32'd1);
               read_reg(reg_data, rd);
               check("reg_data", rd, rec_exp[i]);
               read_reg(reg_ctrl, rd);
               check("reg_ctrl", rd, 32'd0);
            end
            32'd3: set_threshold(rec_chan[i], rec_data[i]);
            32'd4: begin                        // data column holds the ctrl bits
               run_command(rec_chan[i], rec_off[i], 32'd0, rec_data[i]);
               read_reg(reg_ctrl, rd);
               check("reg_ctrl", rd, rec_exp[i]);
               write_reg(reg_ctrl, 32'h1 << error_bit, stalls);  // clear sticky error
               read_reg(reg_ctrl, rd);
               check("reg_ctrl", rd, 32'd0);
            end
            32'd5: begin                        // write, then read issued while busy
               done_start = done_count;
               load_regs(rec_chan[i], rec_off[i], rec_data[i]);
               write_reg(reg_ctrl, 32'd1, stalls);
               write_reg(reg_ctrl, 32'd2, stalls);
               check("host_waitrequest stalled", (stalls > 0) ? 32'd1 : 32'd0, 32'd1);
               wait_done();
               read_reg(reg_data, rd);
               check("reg_data", rd, rec_exp[i]);
               check("host_done count", done_count - done_start, 32'd2);
            end
            default: begin
               $display("record %0d has unknown operation %h", i, rec_op[i]);
               $display("Something failed");
               $fatal(1, "bad test data");
            end
         endcase
      end

      $display("Everything OK");
      $finish;
   end

   // 2000 cycles per record covers a full 64-code sweep with random stalls
   initial begin
      wait (loaded);
      repeat (n_rec * 2000 + 20) @(posedge reconfig_clk);
      $display("watchdog expired after %0d cycles, a command never finished", n_rec * 2000 + 20);
      $display("Something failed");
      $fatal(1, "timeout");
   end

endmodule

//--- sources.f
verilog/dfe_reconfig_pkg.sv
verilog/dfe_user_if.sv
verilog/dfe_tap_map.sv
verilog/dfe_cal_fsm.sv
verilog/dfe_settle_timer.sv
verilog/dfe_basic_master.sv
verilog/dfe_reconfig_top.sv
tb/dfe_base_model.sv
tb/dfe_reconfig_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the DFE reconfig testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f sources.f --top-module dfe_reconfig_tb -o dfe_reconfig_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/dfe_reconfig_sim
status=$?
if [ $status -ne 0 ]; then
   echo "simulation ended with status $status"
   exit $status
fi

echo "simulation exited with status 0"
exit 0

//--- tb/dfe_testdata.txt
# op chan offset data expected, all hex; model memory starts at high 0x80+addr, low 0x40+addr
# op 0 tap write, 1 tap read, 2 calibrate, 3 set threshold, 4 rejected command, 5 busy pair
1 0 0 00 42
1 0 1 00 82
0 0 1 a5 a5
1 0 1 00 a5
1 0 0 00 42
0 1 0 3c 3c
1 1 1 00 92
1 1 0 00 3c
0 2 2 7e 7e
1 2 3 00 a3
1 2 2 00 7e
0 3 3 c1 c1
1 3 2 00 73
1 3 3 00 c1
4 0 5 01 200
4 1 7 02 200
4 2 4 02 200
1 0 1 00 a5
3 1 0 11 0
2 1 4 00 11
3 2 0 5a 0
2 2 4 00 3f
3 0 0 00 0
2 0 4 00 00
5 3 0 5d 5d
1 3 1 00 b2
1 3 3 00 c1
